// File: Makefile
TOP = tb_sdio_device_data_link

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --timescale 1ns/100ps -f filelist.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Simulation PASSED"

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/100ps -f filelist.f --top-module sdio_device_data_link

clean:
	rm -rf obj_dir

// File: filelist.f
verilog/sdio_cmd_pkg.sv
verilog/sdio_card_pkg.sv
verilog/sdio_link_if.sv
verilog/sdio_cmd_decoder.sv
verilog/sdio_func_regs.sv
verilog/sdio_response_builder.sv
verilog/sdio_device_data_link.sv
sim/tb_sdio_device_data_link.sv

// File: sim/sdio_testdata.hex
// columns: cmd arg crc_ok expect response(48 bit) chain, all hex
// chain 1 sends the command in the cycle right after the previous one
// bring-up, op cond then an unselected cmd52
05 00000000 1 1 3FA0FF8000FF 0
34 00000200 1 0 000000000000 0
// addressing
03 00000000 1 1 03000106009F 0
03 00000000 1 1 03000206007D 0
07 00010000 1 0 000000000000 0
07 00020000 1 1 070000060063 0
// register access in functions 0, 1 and 2
34 8000025A 1 1 340000100037 0
34 980002A5 1 1 34000010A58B 0
34 A800023C 1 1 340000103CB9 0
34 00000200 1 1 340000105A79 0
34 10000200 1 1 34000010A58B 0
34 20000200 1 1 340000103CB9 0
34 80000277 1 1 340000105A79 0
34 00000200 1 1 3400001077D7 0
// bad function, address out of range, stored bytes untouched
34 B0000211 1 1 34000012001B 0
34 90002022 1 1 340000110021 0
34 10000000 1 1 340000100037 0
34 10000200 1 1 34000010A58B 0
// dropped, bad crc and unknown opcode
34 00000200 0 0 000000000000 0
08 000001AA 1 0 000000000000 0
// three reads back to back
34 00000200 1 1 3400001077D7 0
34 10000200 1 1 34000010A58B 1
34 20000200 1 1 340000103CB9 1
// go idle, cmd52 silent, op cond answers again
00 00000000 1 0 000000000000 0
34 00000200 1 0 000000000000 0
05 00000000 1 1 3FA0FF8000FF 0

// File: sim/tb_sdio_device_data_link.sv
// sdio data link testbench
module tb_sdio_device_data_link;
  timeunit 1ns;
  timeprecision 100ps;

  // six hex words per record in the data file
  localparam int NUM_RECS    = 26;
  localparam int REC_WORDS   = 6;
  localparam int NUM_WORDS   = NUM_RECS * REC_WORDS;
  localparam int TIMEOUT_CYC = NUM_RECS * 6 + 50;
  // accepted command to response strobe
  localparam int RSP_LAT     = 3;

  logic        sdio_clk;
  logic        rst;
  logic        cmd_stb;
  logic        cmd_crc_stb;
  logic [5:0]  cmd;
  logic [31:0] cmd_arg;
  logic [47:0] rsps;
  logic        rsps_stb;

  logic [47:0] recs [NUM_WORDS];
  // expected responses, tagged with their due cycle
  int          due_q [$];
  logic [47:0] exp_q [$];

  int cycle_cnt   = 0;
  int value_errs  = 0;
  int timing_errs = 0;
  int other_errs  = 0;

  sdio_device_data_link #(
    .NUM_FUNCS (2)
  ) u_dut (
    .sdio_clk    (sdio_clk),
    .rst         (rst),
    .cmd_stb     (cmd_stb),
    .cmd_crc_stb (cmd_crc_stb),
    .cmd         (cmd),
    .cmd_arg     (cmd_arg),
    .rsps        (rsps),
    .rsps_stb    (rsps_stb)
  );

  // 40 ns clock
  initial sdio_clk = 1'b0;
  always #20 sdio_clk = ~sdio_clk;

  always @(posedge sdio_clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // marks words the file never wrote
  function automatic logic [47:0] fill_word(input int idx);
    return {16'hEEEE, 32'(idx)};
  endfunction

  task automatic check_val(input string name, input logic [47:0] got,
                           input logic [47:0] want);
    if (got !== want) begin
      value_errs++;
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, want);
    end
  endtask

  // inputs change 2 ns after the edge
  task automatic idle_cycle();
    @(posedge sdio_clk);
    #2;
    cmd_stb     = 1'b0;
    cmd_crc_stb = 1'b0;
  endtask

  task automatic send_cmd(input logic [5:0] c, input logic [31:0] a, input logic crc_ok);
    @(posedge sdio_clk);
    #2;
    cmd_stb     = 1'b1;
    cmd_crc_stb = crc_ok;
    cmd         = c;
    cmd_arg     = a;
  endtask

  task automatic run_records();
    int i;
    int base;
    int gap;
    for (i = 0; i < NUM_RECS; i++) begin
      base = i * REC_WORDS;
      // chained records go out back to back
      if (recs[base+5][0]) begin
        gap = 0;
      end else begin
        gap = int'($urandom_range(2, 0));
      end
      repeat (gap) idle_cycle();
      send_cmd(recs[base][5:0], recs[base+1][31:0], recs[base+2][0]);
      if (recs[base+3][0]) begin
        due_q.push_back(cycle_cnt + RSP_LAT);
        exp_q.push_back(recs[base+4]);
      end
    end
    idle_cycle();
  endtask

  // response monitor, mid-cycle so outputs have settled
  always @(negedge sdio_clk) begin
    // due cycle passed without a strobe
    while (due_q.size() > 0 && due_q[0] < cycle_cnt) begin
      timing_errs++;
      $display("no response strobe for the command due at cycle %0d", due_q[0]);
      void'(due_q.pop_front());
      void'(exp_q.pop_front());
    end
    if (rsps_stb === 1'b1) begin
      if (due_q.size() > 0 && due_q[0] == cycle_cnt) begin
        check_val("rsps", rsps, exp_q[0]);
        void'(due_q.pop_front());
        void'(exp_q.pop_front());
      end else begin
        timing_errs++;
        $display("response strobe at cycle %0d with no response due", cycle_cnt);
      end
    end
  end

  initial begin : watchdog
    while (cycle_cnt < TIMEOUT_CYC) begin
      @(posedge sdio_clk);
    end
    $display("timeout after %0d cycles, run did not finish", TIMEOUT_CYC);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin : main
    int i;
    int total;
    cmd_stb     = 1'b0;
    cmd_crc_stb = 1'b0;
    cmd         = '0;
    cmd_arg     = '0;
    rst         = 1'b1;
    void'($urandom(72039));
    for (i = 0; i < NUM_WORDS; i++) begin
      recs[i] = fill_word(i);
    end
    $readmemh("sim/sdio_testdata.hex", recs);
    // reset over three edges
    repeat (3) @(posedge sdio_clk);
    #2;
    rst = 1'b0;
    if (recs[NUM_WORDS-1] == fill_word(NUM_WORDS-1)) begin
      other_errs++;
      $display("test data file is missing or holds fewer than %0d records", NUM_RECS);
    end else begin
      run_records();
      // drain the pipeline, then watch for stray strobes
      while (due_q.size() != 0) begin
        @(posedge sdio_clk);
      end
      repeat (4) @(posedge sdio_clk);
    end
    total = value_errs + timing_errs + other_errs;
    $display("errors: %0d value, %0d timing, %0d other", value_errs, timing_errs, other_errs);
    if (total == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: verilog/sdio_card_pkg.sv
// sdio card state and status
package sdio_card_pkg;

  // card state machine
  typedef enum logic [1:0] {
    st_init,
    st_stby,
    st_cmd
  } card_state_e;

  // io_current_state codes in r5
  localparam logic [1:0] IO_STATE_DIS = 2'd0;
  localparam logic [1:0] IO_STATE_CMD = 2'd1;

  // byte window per function
  localparam int unsigned FUNC_ADDR_W = 4;

  // function 0 plus up to 7 io functions
  localparam int unsigned MAX_FUNCS = 8;

  // current_state field of r1 / r6 status
  localparam int unsigned STATUS_STATE_LSB = 9;
  localparam logic [3:0]  STATUS_STBY      = 4'd3;
  localparam logic [3:0]  STATUS_TRAN      = 4'd4;

endpackage

// File: verilog/sdio_cmd_decoder.sv
// sdio command decoder
module sdio_cmd_decoder #(
  parameter int          NUM_FUNCS   = 1,
  parameter int          MEM_PRESENT = 0,
  parameter logic [23:0] IO_OCR      = 24'hFF8000,
  parameter logic [15:0] RCA_BASE    = 16'h0001
) (
  input  logic                    sdio_clk,
  input  logic                    rst,
  input  logic                    cmd_stb,
  input  logic                    cmd_crc_stb,
  input  sdio_cmd_pkg::sdio_cmd_e cmd,
  input  logic [31:0]             cmd_arg,
  sdio_func_if.decoder            func [0:NUM_FUNCS],
  sdio_rsp_req_if.decoder         rsp_req
);

  localparam int unsigned ADDR_FULL_W =
    sdio_cmd_pkg::CMD52_ADDR_MSB - sdio_cmd_pkg::CMD52_ADDR_LSB + 1;

  sdio_card_pkg::card_state_e state_q, state_d;
  logic [15:0]                rca_q, rca_d;
  logic                       accept;
  logic                       rsp_go;
  logic                       acc_go;
  sdio_cmd_pkg::rsp_kind_e    kind_d, kind_q;
  logic [31:0]                arg_d, arg_q;
  logic [7:0]                 r5_flags;

  // cmd52 fields
  logic                   rw_flag;
  logic                   raw_flag;
  logic [2:0]             fn_num;
  logic [ADDR_FULL_W-1:0] addr_full;
  logic [7:0]             wdata;
  logic                   fn_bad;
  logic                   addr_bad;

  // registered outputs
  logic                                  req_stb_q;
  logic [2:0]                            func_q;
  logic                                  use_rdata_q;
  logic [NUM_FUNCS:0]                    acc_stb_q;
  logic                                  acc_wr_q;
  logic                                  acc_raw_q;
  logic [sdio_card_pkg::FUNC_ADDR_W-1:0] acc_addr_q;
  logic [7:0]                            acc_wdata_q;

  // r1/r6 status with the current_state field filled in
  function automatic logic [15:0] status_bits(input sdio_card_pkg::card_state_e s);
    logic [15:0] st;
    st = '0;
    st[sdio_card_pkg::STATUS_STATE_LSB +: 4] = (s == sdio_card_pkg::st_cmd) ?
      sdio_card_pkg::STATUS_TRAN : sdio_card_pkg::STATUS_STBY;
    return st;
  endfunction

  function automatic logic [1:0] io_state(input sdio_card_pkg::card_state_e s);
    return (s == sdio_card_pkg::st_cmd) ? sdio_card_pkg::IO_STATE_CMD :
      sdio_card_pkg::IO_STATE_DIS;
  endfunction

  assign accept    = cmd_stb && cmd_crc_stb;
  assign rw_flag   = cmd_arg[sdio_cmd_pkg::CMD52_RW_BIT];
  assign raw_flag  = cmd_arg[sdio_cmd_pkg::CMD52_RAW_BIT];
  assign fn_num    = cmd_arg[sdio_cmd_pkg::CMD52_FN_MSB:sdio_cmd_pkg::CMD52_FN_LSB];
  assign addr_full = cmd_arg[sdio_cmd_pkg::CMD52_ADDR_MSB:sdio_cmd_pkg::CMD52_ADDR_LSB];
  assign wdata     = cmd_arg[sdio_cmd_pkg::CMD52_DATA_MSB:0];
  assign fn_bad    = int'(fn_num) > NUM_FUNCS;
  // anything past the 16-byte window
  assign addr_bad  = |addr_full[ADDR_FULL_W-1:sdio_card_pkg::FUNC_ADDR_W];

  always_comb begin
    r5_flags = '0;
    r5_flags[sdio_cmd_pkg::R5_OOR_BIT] = addr_bad;
    r5_flags[sdio_cmd_pkg::R5_FN_BIT]  = fn_bad;
    r5_flags[sdio_cmd_pkg::R5_STATE_MSB:sdio_cmd_pkg::R5_STATE_LSB] = io_state(state_q);
  end

  always_comb begin
    state_d = state_q;
    rca_d   = rca_q;
    rsp_go  = 1'b0;
    acc_go  = 1'b0;
    kind_d  = sdio_cmd_pkg::rsp_r1;
    arg_d   = '0;
    if (accept) begin
      case (cmd)
        sdio_cmd_pkg::go_idle: begin
          // back to init, silently
          state_d = sdio_card_pkg::st_init;
          rca_d   = '0;
        end
        sdio_cmd_pkg::io_send_op_cond: begin
          if (state_q != sdio_card_pkg::st_cmd) begin
            rsp_go = 1'b1;
            kind_d = sdio_cmd_pkg::rsp_r4;
            arg_d[sdio_cmd_pkg::R4_READY_BIT] = 1'b1;
            arg_d[sdio_cmd_pkg::R4_NF_MSB:sdio_cmd_pkg::R4_NF_LSB] = 3'(NUM_FUNCS);
            arg_d[sdio_cmd_pkg::R4_MEM_BIT] = 1'(MEM_PRESENT);
            arg_d[sdio_cmd_pkg::R4_OCR_MSB:0] = IO_OCR;
          end
        end
        sdio_cmd_pkg::send_rca: begin
          if (state_q != sdio_card_pkg::st_cmd) begin
            // first issue takes the base, later ones step
            rca_d   = (rca_q == '0) ? RCA_BASE : rca_q + 16'd1;
            state_d = sdio_card_pkg::st_stby;
            rsp_go  = 1'b1;
            kind_d  = sdio_cmd_pkg::rsp_r6;
            arg_d   = {rca_d, status_bits(sdio_card_pkg::st_stby)};
          end
        end
        sdio_cmd_pkg::sel_desel: begin
          if (rca_q != '0 && cmd_arg[31:16] == rca_q) begin
            state_d = sdio_card_pkg::st_cmd;
            rsp_go  = 1'b1;
            kind_d  = sdio_cmd_pkg::rsp_r1;
            // status reports the state before selection
            arg_d   = {16'h0000, status_bits(state_q)};
          end else if (state_q != sdio_card_pkg::st_init) begin
            // deselect, no answer
            state_d = sdio_card_pkg::st_stby;
          end
        end
        sdio_cmd_pkg::io_rw_direct: begin
          if (state_q == sdio_card_pkg::st_cmd) begin
            rsp_go = 1'b1;
            kind_d = sdio_cmd_pkg::rsp_r5;
            acc_go = !fn_bad && !addr_bad;
            arg_d[sdio_cmd_pkg::R5_FLAGS_LSB +: 8] = r5_flags;
          end
        end
        default: begin
          // unsupported, dropped
        end
      endcase
    end
  end

  always_ff @(posedge sdio_clk) begin
    if (rst) begin
      state_q   <= sdio_card_pkg::st_init;
      rca_q     <= '0;
      req_stb_q <= 1'b0;
      acc_stb_q <= '0;
    end else begin
      state_q   <= state_d;
      rca_q     <= rca_d;
      req_stb_q <= rsp_go;
      // one-hot strobe to the addressed window
      for (int i = 0; i <= NUM_FUNCS; i++) begin
        acc_stb_q[i] <= acc_go && (fn_num == 3'(i));
      end
    end
  end

  // payload, qualified by the strobes
  always_ff @(posedge sdio_clk) begin
    kind_q      <= kind_d;
    arg_q       <= arg_d;
    func_q      <= fn_num;
    use_rdata_q <= acc_go;
    acc_wr_q    <= rw_flag;
    acc_raw_q   <= raw_flag;
    acc_addr_q  <= addr_full[sdio_card_pkg::FUNC_ADDR_W-1:0];
    acc_wdata_q <= wdata;
  end

  assign rsp_req.req_stb   = req_stb_q;
  assign rsp_req.kind      = kind_q;
  assign rsp_req.arg       = arg_q;
  assign rsp_req.func      = func_q;
  assign rsp_req.use_rdata = use_rdata_q;

  for (genvar g = 0; g <= NUM_FUNCS; g++) begin : g_func
    assign func[g].acc_stb = acc_stb_q[g];
    assign func[g].wr      = acc_wr_q;
    assign func[g].raw     = acc_raw_q;
    assign func[g].addr    = acc_addr_q;
    assign func[g].wdata   = acc_wdata_q;
  end

endmodule

// File: verilog/sdio_cmd_pkg.sv
// sdio command and response fields
package sdio_cmd_pkg;

  // supported command opcodes
  typedef enum logic [5:0] {
    go_idle         = 6'd0,
    send_rca        = 6'd3,
    io_send_op_cond = 6'd5,
    sel_desel       = 6'd7,
    io_rw_direct    = 6'd52
  } sdio_cmd_e;

  // response formats we build
  typedef enum logic [1:0] {
    rsp_r1,
    rsp_r4,
    rsp_r5,
    rsp_r6
  } rsp_kind_e;

  // cmd52 argument
  localparam int unsigned CMD52_RW_BIT   = 31;
  localparam int unsigned CMD52_FN_MSB   = 30;
  localparam int unsigned CMD52_FN_LSB   = 28;
  localparam int unsigned CMD52_RAW_BIT  = 27;
  localparam int unsigned CMD52_ADDR_MSB = 25;
  localparam int unsigned CMD52_ADDR_LSB = 9;
  localparam int unsigned CMD52_DATA_MSB = 7;

  // r5 flag byte, sits at arg[15:8]
  localparam int unsigned R5_FLAGS_LSB = 8;
  localparam int unsigned R5_OOR_BIT   = 0;
  localparam int unsigned R5_FN_BIT    = 1;
  localparam int unsigned R5_STATE_MSB = 5;
  localparam int unsigned R5_STATE_LSB = 4;

  // r4 argument
  localparam int unsigned R4_READY_BIT = 31;
  localparam int unsigned R4_NF_MSB    = 30;
  localparam int unsigned R4_NF_LSB    = 28;
  localparam int unsigned R4_MEM_BIT   = 27;
  localparam int unsigned R4_OCR_MSB   = 23;

  // r4 carries no real index or crc
  localparam logic [5:0] R4_INDEX = 6'h3F;
  localparam logic [6:0] R4_CRC   = 7'h7F;

endpackage

// File: verilog/sdio_device_data_link.sv
// sdio device data link top
module sdio_device_data_link #(
  parameter int          NUM_FUNCS   = 1,
  parameter int          MEM_PRESENT = 0,
  parameter logic [23:0] IO_OCR      = 24'hFF8000,
  parameter logic [15:0] RCA_BASE    = 16'h0001
) (
  input  logic        sdio_clk,
  input  logic        rst,
  // phy side, whole commands
  input  logic        cmd_stb,
  input  logic        cmd_crc_stb,
  input  logic [5:0]  cmd,
  input  logic [31:0] cmd_arg,
  // response back to the phy
  output logic [47:0] rsps,
  output logic        rsps_stb
);

  // function 0 plus NUM_FUNCS io functions
  sdio_func_if    func_bus [0:NUM_FUNCS] ();
  sdio_rsp_req_if rsp_req ();

  sdio_cmd_decoder #(
    .NUM_FUNCS   (NUM_FUNCS),
    .MEM_PRESENT (MEM_PRESENT),
    .IO_OCR      (IO_OCR),
    .RCA_BASE    (RCA_BASE)
  ) u_decoder (
    .sdio_clk    (sdio_clk),
    .rst         (rst),
    .cmd_stb     (cmd_stb),
    .cmd_crc_stb (cmd_crc_stb),
    .cmd         (sdio_cmd_pkg::sdio_cmd_e'(cmd)),
    .cmd_arg     (cmd_arg),
    .func        (func_bus),
    .rsp_req     (rsp_req)
  );

  for (genvar g = 0; g <= NUM_FUNCS; g++) begin : g_func
    sdio_func_regs u_regs (
      .sdio_clk (sdio_clk),
      .rst      (rst),
      .bus      (func_bus[g])
    );
  end

  sdio_response_builder #(
    .NUM_FUNCS (NUM_FUNCS)
  ) u_builder (
    .sdio_clk (sdio_clk),
    .rst      (rst),
    .func     (func_bus),
    .rsp_req  (rsp_req),
    .rsps     (rsps),
    .rsps_stb (rsps_stb)
  );

endmodule

// File: verilog/sdio_func_regs.sv
// sdio function register window
module sdio_func_regs (
  input  logic     sdio_clk,
  input  logic     rst,
  sdio_func_if.regs bus
);

  localparam int unsigned DEPTH = 1 << sdio_card_pkg::FUNC_ADDR_W;

  logic [7:0] mem [DEPTH];
  logic [7:0] rd_byte;

  // raw write reads back the new byte, plain write the old one
  always_comb begin
    if (bus.wr && bus.raw) begin
      rd_byte = bus.wdata;
    end else begin
      rd_byte = mem[bus.addr];
    end
  end

  always_ff @(posedge sdio_clk) begin
    if (rst) begin
      // window comes up all zero
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= 8'h00;
      end
      bus.rdata <= 8'h00;
    end else if (bus.acc_stb) begin
      if (bus.wr) begin
        mem[bus.addr] <= bus.wdata;
      end
      // rdata held until next access
      bus.rdata <= rd_byte;
    end
  end

endmodule

// File: verilog/sdio_link_if.sv
// sdio internal link interfaces

// one per function window
interface sdio_func_if;
  logic                                 acc_stb;
  logic                                 wr;
  logic                                 raw;
  logic [sdio_card_pkg::FUNC_ADDR_W-1:0] addr;
  logic [7:0]                           wdata;
  logic [7:0]                           rdata;

  modport decoder (output acc_stb, wr, raw, addr, wdata);
  modport regs    (input acc_stb, wr, raw, addr, wdata, output rdata);
  modport builder (input rdata);
endinterface

// response request, decoder to builder
interface sdio_rsp_req_if;
  logic                    req_stb;
  sdio_cmd_pkg::rsp_kind_e kind;
  logic [31:0]             arg;
  logic [2:0]              func;
  logic                    use_rdata;

  modport decoder (output req_stb, kind, arg, func, use_rdata);
  modport builder (input req_stb, kind, arg, func, use_rdata);
endinterface

// File: verilog/sdio_response_builder.sv
// sdio response builder
module sdio_response_builder #(
  parameter int NUM_FUNCS = 1
) (
  input  logic            sdio_clk,
  input  logic            rst,
  sdio_func_if.builder    func [0:NUM_FUNCS],
  sdio_rsp_req_if.builder rsp_req,
  output logic [47:0]     rsps,
  output logic            rsps_stb
);

  // stage 1, request waits for the window read
  logic                    req_v;
  sdio_cmd_pkg::rsp_kind_e kind_q;
  logic [31:0]             arg_q;
  logic [2:0]              func_q;
  logic                    use_rdata_q;

  // stage 2
  logic [7:0]  rdata_all [sdio_card_pkg::MAX_FUNCS];
  logic [31:0] arg_m;
  logic [5:0]  index;
  logic [39:0] body;
  logic [6:0]  crc_f;

  // crc7, x^7 + x^3 + 1, msb first
  function automatic logic [6:0] crc7(input logic [39:0] data);
    logic [6:0] crc;
    logic       fb;
    crc = '0;
    for (int i = 39; i >= 0; i--) begin
      fb     = data[i] ^ crc[6];
      crc    = {crc[5:0], fb};
      crc[3] = crc[3] ^ fb;
    end
    return crc;
  endfunction

  // unused slots read as zero so any 3-bit func indexes safely
  for (genvar g = 0; g < sdio_card_pkg::MAX_FUNCS; g++) begin : g_rdata
    if (g <= NUM_FUNCS) begin : g_used
      assign rdata_all[g] = func[g].rdata;
    end else begin : g_unused
      assign rdata_all[g] = 8'h00;
    end
  end

  always_ff @(posedge sdio_clk) begin
    if (rst) begin
      req_v <= 1'b0;
    end else begin
      req_v <= rsp_req.req_stb;
    end
  end

  always_ff @(posedge sdio_clk) begin
    kind_q      <= rsp_req.kind;
    arg_q       <= rsp_req.arg;
    func_q      <= rsp_req.func;
    use_rdata_q <= rsp_req.use_rdata;
  end

  // merge read data, r5 only
  always_comb begin
    arg_m = arg_q;
    if (kind_q == sdio_cmd_pkg::rsp_r5 && use_rdata_q) begin
      arg_m[7:0] = rdata_all[func_q];
    end
  end

  // index follows from the response kind
  always_comb begin
    case (kind_q)
      sdio_cmd_pkg::rsp_r1: index = sdio_cmd_pkg::sel_desel;
      sdio_cmd_pkg::rsp_r4: index = sdio_cmd_pkg::R4_INDEX;
      sdio_cmd_pkg::rsp_r5: index = sdio_cmd_pkg::io_rw_direct;
      default:              index = sdio_cmd_pkg::send_rca;
    endcase
  end

  // start and direction bits both 0
  assign body  = {2'b00, index, arg_m};
  assign crc_f = (kind_q == sdio_cmd_pkg::rsp_r4) ? sdio_cmd_pkg::R4_CRC : crc7(body);

  always_ff @(posedge sdio_clk) begin
    if (rst) begin
      rsps_stb <= 1'b0;
    end else begin
      rsps_stb <= req_v;
    end
  end

  // end bit 1
  always_ff @(posedge sdio_clk) begin
    if (req_v) begin
      rsps <= {body, crc_f, 1'b1};
    end
  end

endmodule
